// File: Makefile
# Verilator flow for the fetch front end

VERILATOR   ?= verilator
TOP         ?= tb_fetch_frontend
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
LOG         ?= sim.log
PASS_TEXT   ?= Verification passed
LINT_FLAGS  ?= --lint-only --timing
BUILD_FLAGS ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	rm -f $(LOG)
	-$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/fetch_frontend_sva.sv
// Bound protocol checks on issue, fill request and flush behavior of the fetch front end
`timescale 1ns/1ps

module fetch_frontend_sva import fetch_pkg::*; (
  input logic         clk_i,
  input logic         rst_n_i,
  input logic         flush_i,
  input logic         issue_valid_i,
  input logic         issue_ready_i,
  input instr_t       instr_i,
  input xlen_t        pc_i,
  input logic         except_i,
  input except_code_t except_code_i,
  input logic         mem_req_i,
  input xlen_t        mem_addr_i,
  input logic         mem_valid_i,
  input logic         read_req_i,
  input logic         read_done_i,
  input logic         fill_busy_i
);

  // ------------------------------------------------------------------------
  // Memory port
  // ------------------------------------------------------------------------
  // Request and address hold until the answer
  mem_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i && !mem_valid_i |=> mem_req_i && $stable(mem_addr_i))
    else $error("mem_req_o dropped or mem_addr_o moved before mem_valid_i");

  // Request low for a cycle after the answer
  mem_req_drop_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_req_i && mem_valid_i |=> !mem_req_i)
    else $error("mem_req_o still high after mem_valid_i");

  // ------------------------------------------------------------------------
  // Fill stage handshake
  // ------------------------------------------------------------------------
  read_req_free_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_req_i |-> !fill_busy_i)
    else $error("read_req while fill stage busy");

  read_done_free_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_done_i |-> !fill_busy_i)
    else $error("read_done while fill stage busy");

  // ------------------------------------------------------------------------
  // Issue port
  // ------------------------------------------------------------------------
  flush_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |-> !issue_valid_i)
    else $error("issue_valid_o high in a flush cycle");

  // Stalled instruction holds unless a flush takes it away
  issue_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i && !issue_ready_i && !flush_i |=> flush_i ||
      (issue_valid_i && $stable(instr_i) && $stable(pc_i) &&
       $stable(except_i) && $stable(except_code_i)))
    else $error("issue outputs changed during a stall");

endmodule

// File: bench/tb_fetch_frontend.sv
// Testbench for the fetch front end with line memory model and table driven redirects
`timescale 1ns/1ps

module tb_fetch_frontend import fetch_pkg::*; ();

  localparam xlen_t BOOT_PC  = 32'h0000_0100;
  localparam int    NUM_ROWS = 6;
  localparam int    LIMIT    = 64;

  // One redirect with its expected run
  typedef struct packed {
    logic         do_flush;
    logic         wait_fill;
    logic         stall;
    xlen_t        start_pc;
    logic [7:0]   count;
    except_code_t first_code;
  } row_t;

  logic         clk_i         = 1'b0;
  logic         rst_n_i       = 1'b0;
  logic         flush_i       = 1'b0;
  xlen_t        redirect_pc_i = '0;
  logic         issue_ready_i = 1'b0;
  logic         mem_valid_i   = 1'b0;
  line_data_t   mem_line_i    = '0;
  fill_err_t    mem_err_i     = FILL_OK;
  logic         issue_valid_o;
  instr_t       instr_o;
  xlen_t        pc_o;
  logic         except_o;
  except_code_t except_code_o;
  logic         mem_req_o;
  xlen_t        mem_addr_o;

  row_t   rows [NUM_ROWS];
  integer seed      = 12380;
  integer lat_seed  = 12380;
  int     checks    = 0;
  int     errors    = 0;
  int     tests     = 0;
  logic   timed_out = 1'b0;
  logic   serving   = 1'b0;
  int     wait_cnt  = 0;

  always #2 clk_i = ~clk_i;

  fetch_frontend #(.BOOT_PC(BOOT_PC)) dut0 (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i), .redirect_pc_i (redirect_pc_i),
    .issue_valid_o (issue_valid_o), .issue_ready_i (issue_ready_i), .instr_o (instr_o),
    .pc_o (pc_o), .except_o (except_o), .except_code_o (except_code_o),
    .mem_req_o (mem_req_o), .mem_addr_o (mem_addr_o), .mem_valid_i (mem_valid_i),
    .mem_line_i (mem_line_i), .mem_err_i (mem_err_i)
  );

  bind fetch_frontend fetch_frontend_sva u_fetch_frontend_sva (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .flush_i (flush_i),
    .issue_valid_i (issue_valid_o), .issue_ready_i (issue_ready_i), .instr_i (instr_o),
    .pc_i (pc_o), .except_i (except_o), .except_code_i (except_code_o),
    .mem_req_i (mem_req_o), .mem_addr_i (mem_addr_o), .mem_valid_i (mem_valid_i),
    .read_req_i (read_req), .read_done_i (read_done), .fill_busy_i (fill_busy)
  );

  // ------------------------------------------------------------------------
  // Memory model with words at address XOR a fixed tag and two fault regions
  // ------------------------------------------------------------------------
  function automatic line_data_t line_words(input xlen_t addr);
    line_data_t d;
    for (int k = 0; k < LINE_WORDS; k++) begin
      d[k*ILEN +: ILEN] = (addr + xlen_t'(4 * k)) ^ 32'hA5A5_0000;
    end
    return d;
  endfunction

  function automatic fill_err_t fill_err_for(input xlen_t addr);
    if (addr >= 32'h800 && addr <= 32'h8FF) begin
      return FILL_PAGE_FAULT;
    end else if (addr >= 32'h900 && addr <= 32'h9FF) begin
      return FILL_ACCESS_FAULT;
    end else begin
      return FILL_OK;
    end
  endfunction

  // Cause that decode must see for a pc
  function automatic except_code_t code_for(input xlen_t pc);
    if (pc >= 32'h800 && pc <= 32'h8FF) begin
      return E_INSTR_PAGE_FAULT;
    end else if (pc >= 32'h900 && pc <= 32'h9FF) begin
      return E_I_ACCESS_FAULT;
    end else begin
      return E_NONE;
    end
  endfunction

  // Answers after 1 to 4 cycles
  always @(posedge clk_i) begin
    mem_valid_i <= 1'b0;
    if (mem_req_o && !mem_valid_i) begin
      if (!serving) begin
        serving  <= 1'b1;
        wait_cnt <= 1 + int'($unsigned($random(lat_seed)) % 4);
      end else if (wait_cnt > 1) begin
        wait_cnt <= wait_cnt - 1;
      end else begin
        serving     <= 1'b0;
        mem_valid_i <= 1'b1;
        mem_line_i  <= line_words(mem_addr_o);
        mem_err_i   <= fill_err_for(mem_addr_o);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------------------
  task automatic check_instr(input instr_t got, input instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t instr_o got=%h exp=%h", $time, got, exp);
    end
  endtask

  task automatic check_pc(input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t pc_o got=%h exp=%h", $time, got, exp);
    end
  endtask

  task automatic check_except(input except_code_t got, input except_code_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t except_code_o got=%0d exp=%0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  function automatic logic next_ready(input logic stall);
    if (stall) begin
      return ($unsigned($random(seed)) % 4) != 0;
    end else begin
      return 1'b1;
    end
  endfunction

  // ------------------------------------------------------------------------
  // One table row with an optional flush and the transfers it collects
  // ------------------------------------------------------------------------
  task automatic run_row(input int idx);
    row_t         r;
    xlen_t        exp_pc;
    except_code_t exp_code;
    int           got;
    int           guard;
    int           err0;
    r      = rows[idx];
    err0   = errors;
    exp_pc = r.start_pc;
    got    = 0;
    guard  = 0;
    // Hit a fill in flight so the flush drops it
    while (r.wait_fill && !mem_req_o) begin
      @(posedge clk_i);
      guard++;
      if (guard > LIMIT) begin
        $display("Row %0d: no memory request seen before the flush", idx);
        timed_out = 1'b1;
        return;
      end
    end
    if (r.do_flush) begin
      flush_i       <= 1'b1;
      redirect_pc_i <= r.start_pc;
      @(posedge clk_i);
      flush_i       <= 1'b0;
    end
    guard = 0;
    issue_ready_i <= next_ready(r.stall);
    while (got < int'(r.count)) begin
      @(posedge clk_i);
      if (issue_valid_o && issue_ready_i) begin
        exp_code = (got == 0) ? r.first_code : code_for(exp_pc);
        check_pc(pc_o, exp_pc);
        check_instr(instr_o, exp_pc ^ 32'hA5A5_0000);
        check_flag("except_o", except_o, exp_code != E_NONE);
        check_except(except_code_o, exp_code);
        exp_pc += PC_STEP;
        got++;
        guard = 0;
      end else begin
        guard++;
        if (guard > LIMIT) begin
          $display("Row %0d: no transfer within %0d cycles", idx, LIMIT);
          timed_out = 1'b1;
          return;
        end
      end
      issue_ready_i <= (got < int'(r.count)) ? next_ready(r.stall) : 1'b0;
    end
    tests++;
    $display("Test %0d: start %h, %0d transfers, %s", idx, r.start_pc, got,
             (errors == err0) ? "ok" : "mismatch");
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    // flush, wait_fill, stall, start pc, count, first cause
    rows[0] = '{1'b0, 1'b0, 1'b0, BOOT_PC,      8'd12, E_NONE};
    rows[1] = '{1'b1, 1'b1, 1'b1, 32'h0000_0200, 8'd10, E_NONE};
    rows[2] = '{1'b1, 1'b0, 1'b0, 32'h0000_0308, 8'd6,  E_NONE};
    rows[3] = '{1'b1, 1'b1, 1'b1, 32'h0000_0804, 8'd5,  E_INSTR_PAGE_FAULT};
    rows[4] = '{1'b1, 1'b0, 1'b0, 32'h0000_09F8, 8'd4,  E_I_ACCESS_FAULT};
    rows[5] = '{1'b1, 1'b0, 1'b1, 32'h0000_040C, 8'd9,  E_NONE};
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    check_flag("issue_valid_o", issue_valid_o, 1'b0);
    check_flag("mem_req_o", mem_req_o, 1'b0);
    for (int i = 0; i < NUM_ROWS && !timed_out; i++) begin
      run_row(i);
    end
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: project.f
source/fetch_pkg.sv
source/pc_gen.sv
source/fetch_controller.sv
source/ifu.sv
source/line_fill.sv
source/fetch_frontend.sv
bench/fetch_frontend_sva.sv
bench/tb_fetch_frontend.sv

// File: source/fetch_controller.sv
// Fetch controller FSM ordering line requests, issue valid and fetch ready
`timescale 1ns/1ps

module fetch_controller import fetch_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,

  // Current pc is in the stored line
  input  logic here_i,

  // Decode side
  input  logic issue_ready_i,

  // Line fill side
  input  logic read_done_i,
  input  logic fill_busy_i,

  // Outputs
  output logic fetch_ready_o,
  output logic read_req_o,
  output logic issue_valid_o,
  output logic line_sel_o
);

  fetch_state_t state_q;
  fetch_state_t state_d;

  // ------------------------------------------------------------------------
  // Next state and outputs
  // ------------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    fetch_ready_o = 1'b0;
    read_req_o    = 1'b0;
    issue_valid_o = 1'b0;
    line_sel_o    = 1'b0;

    if (flush_i) begin
      // Restart from scratch with nothing issued this cycle
      state_d = IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (here_i) begin
            // Hit in the line register
            issue_valid_o = 1'b1;
            fetch_ready_o = issue_ready_i;
          end else if (!fill_busy_i) begin
            // Miss with the fill stage free
            read_req_o = 1'b1;
            state_d    = WAIT_LINE;
          end else begin
            // Miss behind a dropped fill still in flight
            state_d = REQUEST;
          end
        end

        REQUEST: begin
          // Hold off until the old fill is gone
          if (!fill_busy_i) begin
            read_req_o = 1'b1;
            state_d    = WAIT_LINE;
          end
        end

        WAIT_LINE: begin
          if (read_done_i) begin
            // Issue straight from the incoming line
            issue_valid_o = 1'b1;
            line_sel_o    = 1'b1;
            fetch_ready_o = issue_ready_i;
            // Line register holds it next cycle and a stall
            // turns into a hit with the same pc
            state_d       = IDLE;
          end
        end

        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // State register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: source/fetch_frontend.sv
// Fetch front end top level joining PC stage, fetch unit and line fill
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; #(
  parameter xlen_t BOOT_PC = 32'h0000_0000
) (
  input  logic         clk_i,
  input  logic         rst_n_i,

  // Redirect
  input  logic         flush_i,
  input  xlen_t        redirect_pc_i,

  // Issue to decode
  output logic         issue_valid_o,
  input  logic         issue_ready_i,
  output instr_t       instr_o,
  output xlen_t        pc_o,
  output logic         except_o,
  output except_code_t except_code_o,

  // Line memory
  output logic         mem_req_o,
  output xlen_t        mem_addr_o,
  input  logic         mem_valid_i,
  input  line_data_t   mem_line_i,
  input  fill_err_t    mem_err_i
);

  xlen_t pc;
  logic  fetch_ready;
  logic  read_req;
  xlen_t read_addr;
  logic  fill_busy;
  logic  read_done;
  line_t fill_line;

  // PC stage
  pc_gen #(
    .BOOT_PC (BOOT_PC)
  ) u_pc_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .redirect_pc_i (redirect_pc_i),
    .fetch_ready_i (fetch_ready),
    .pc_o          (pc)
  );

  // Fetch unit
  ifu u_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pc_i          (pc),
    .fetch_ready_o (fetch_ready),
    .fill_line_i   (fill_line),
    .read_done_i   (read_done),
    .fill_busy_i   (fill_busy),
    .read_req_o    (read_req),
    .read_addr_o   (read_addr),
    .issue_ready_i (issue_ready_i),
    .issue_valid_o (issue_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .except_o      (except_o),
    .except_code_o (except_code_o)
  );

  // Line fill
  line_fill u_line_fill (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .read_req_i  (read_req),
    .read_addr_i (read_addr),
    .fill_busy_o (fill_busy),
    .read_done_o (read_done),
    .fill_line_o (fill_line),
    .mem_req_o   (mem_req_o),
    .mem_addr_o  (mem_addr_o),
    .mem_valid_i (mem_valid_i),
    .mem_line_i  (mem_line_i),
    .mem_err_i   (mem_err_i)
  );

endmodule

// File: source/fetch_pkg.sv
// Fetch front end package with widths, line layout, fill errors and exception causes

package fetch_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int ILEN       = 32;
  localparam int LINE_WORDS = 4;
  localparam int OFFSET_W   = 2;

  // Byte offset inside one instruction, then first bit above the line
  localparam int WORD_LSB = 2;
  localparam int LINE_LSB = WORD_LSB + OFFSET_W;

  typedef logic [XLEN-1:0]            xlen_t;
  typedef logic [ILEN-1:0]            instr_t;
  typedef logic [LINE_WORDS*ILEN-1:0] line_data_t;

  // Sequential step of the fetch PC
  localparam xlen_t PC_STEP = xlen_t'(ILEN / 8);

  // ------------------------------------------------------------------------
  // Memory error answer and exception causes
  // ------------------------------------------------------------------------
  typedef logic [1:0] fill_err_t;

  localparam fill_err_t FILL_OK           = 2'd0;
  localparam fill_err_t FILL_PAGE_FAULT   = 2'd1;
  localparam fill_err_t FILL_ACCESS_FAULT = 2'd2;

  typedef logic [3:0] except_code_t;

  // E_NONE doubles as the unknown cause
  localparam except_code_t E_NONE             = 4'd0;
  localparam except_code_t E_I_ACCESS_FAULT   = 4'd1;
  localparam except_code_t E_INSTR_PAGE_FAULT = 4'd12;

  // One filled line: aligned pc, payload and error
  typedef struct packed {
    xlen_t      pc;
    line_data_t data;
    fill_err_t  err;
  } line_t;

  // Fetch controller states
  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_LINE
  } fetch_state_t;

endpackage

// File: source/ifu.sv
// Instruction fetch unit with line register, hit check, word select and exception map
`timescale 1ns/1ps

module ifu import fetch_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         flush_i,

  // PC stage
  input  xlen_t        pc_i,
  output logic         fetch_ready_o,

  // Line fill stage
  input  line_t        fill_line_i,
  input  logic         read_done_i,
  input  logic         fill_busy_i,
  output logic         read_req_o,
  output xlen_t        read_addr_o,

  // Decode
  input  logic         issue_ready_i,
  output logic         issue_valid_o,
  output instr_t       instr_o,
  output xlen_t        pc_o,
  output logic         except_o,
  output except_code_t except_code_o
);

  line_t                line_q;
  logic                 line_valid_q;
  logic                 here;
  logic                 line_sel;
  logic                 except_flag;
  xlen_t                pc_line;
  line_t                src_line;
  logic [OFFSET_W-1:0]  word_off;

  // ------------------------------------------------------------------------
  // Line register
  // ------------------------------------------------------------------------
  // Valid flag of the stored line
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_valid_q <= 1'b0;
    end else if (flush_i) begin
      line_valid_q <= 1'b0;
    end else if (read_done_i) begin
      line_valid_q <= 1'b1;
    end
  end

  // Flushed lines never land here
  always_ff @(posedge clk_i) begin
    if (read_done_i && !flush_i) begin
      line_q <= fill_line_i;
    end
  end

  // ------------------------------------------------------------------------
  // Presence check
  // ------------------------------------------------------------------------
  assign pc_line  = {pc_i[XLEN-1:LINE_LSB], {LINE_LSB{1'b0}}};
  assign word_off = pc_i[LINE_LSB-1:WORD_LSB];
  assign here     = line_valid_q && (pc_line == line_q.pc);

  // Misses fetch the whole aligned line
  assign read_addr_o = pc_line;

  // ------------------------------------------------------------------------
  // Controller
  // ------------------------------------------------------------------------
  fetch_controller u_fetch_controller (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .here_i        (here),
    .issue_ready_i (issue_ready_i),
    .read_done_i   (read_done_i),
    .fill_busy_i   (fill_busy_i),
    .fetch_ready_o (fetch_ready_o),
    .read_req_o    (read_req_o),
    .issue_valid_o (issue_valid_o),
    .line_sel_o    (line_sel)
  );

  // ------------------------------------------------------------------------
  // Instruction select
  // ------------------------------------------------------------------------
  // Fill bypass in its done cycle or the stored line
  assign src_line = line_sel ? fill_line_i : line_q;
  assign instr_o  = src_line.data[word_off*ILEN +: ILEN];
  assign pc_o     = pc_i;

  // ------------------------------------------------------------------------
  // Exception map
  // ------------------------------------------------------------------------
  always_comb begin
    case (src_line.err)
      FILL_OK: begin
        except_code_o = E_NONE;
        except_flag   = 1'b0;
      end
      FILL_PAGE_FAULT: begin
        except_code_o = E_INSTR_PAGE_FAULT;
        except_flag   = 1'b1;
      end
      FILL_ACCESS_FAULT: begin
        except_code_o = E_I_ACCESS_FAULT;
        except_flag   = 1'b1;
      end
      default: begin
        // Unknown error flagged without a cause
        except_code_o = E_NONE;
        except_flag   = 1'b1;
      end
    endcase
  end

  // Exception only counts with a valid instruction
  assign except_o = issue_valid_o & except_flag;

endmodule

// File: source/line_fill.sv
// Line fill stage, holds the memory request and returns the line with a done pulse
`timescale 1ns/1ps

module line_fill import fetch_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       flush_i,

  // Fetch unit side
  input  logic       read_req_i,
  input  xlen_t      read_addr_i,
  output logic       fill_busy_o,
  output logic       read_done_o,
  output line_t      fill_line_o,

  // External line memory
  output logic       mem_req_o,
  output xlen_t      mem_addr_o,
  input  logic       mem_valid_i,
  input  line_data_t mem_line_i,
  input  fill_err_t  mem_err_i
);

  logic  busy_q;
  logic  drop_q;
  logic  done_q;
  xlen_t addr_q;
  line_t line_q;

  // ------------------------------------------------------------------------
  // Request and drop control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      drop_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (busy_q) begin
        if (mem_valid_i) begin
          // Answer in and the request drops
          busy_q <= 1'b0;
          drop_q <= 1'b0;
          // Flushed fills finish silently
          done_q <= !(drop_q || flush_i);
        end else if (flush_i) begin
          drop_q <= 1'b1;
        end
      end else if (read_req_i) begin
        busy_q <= 1'b1;
      end
    end
  end

  // Request address held while busy
  always_ff @(posedge clk_i) begin
    if (!busy_q && read_req_i) begin
      addr_q <= read_addr_i;
    end
  end

  // Capture the answer with its address and error
  always_ff @(posedge clk_i) begin
    if (busy_q && mem_valid_i) begin
      line_q.pc   <= addr_q;
      line_q.data <= mem_line_i;
      line_q.err  <= mem_err_i;
    end
  end

  // ------------------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------------------
  assign mem_req_o   = busy_q;
  assign mem_addr_o  = addr_q;
  assign fill_busy_o = busy_q;
  assign read_done_o = done_q;
  assign fill_line_o = line_q;

endmodule

// File: source/pc_gen.sv
// Program counter stage, boot address, sequential advance and flush redirect
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; #(
  parameter xlen_t BOOT_PC = 32'h0000_0000
) (
  input  logic  clk_i,
  input  logic  rst_n_i,

  // Redirect from the back end
  input  logic  flush_i,
  input  xlen_t redirect_pc_i,

  // Transfer to decode took place
  input  logic  fetch_ready_i,

  // Address currently being fetched
  output xlen_t pc_o
);

  xlen_t pc_q;
  xlen_t pc_d;

  // Next PC select
  // Flush beats the sequential step
  always_comb begin
    pc_d = pc_q;
    if (flush_i) begin
      pc_d = redirect_pc_i;
    end else if (fetch_ready_i) begin
      pc_d = pc_q + PC_STEP;
    end
  end

  // PC register, starts at the boot address
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule
